/* src/pitch_pkg.sv */
package pitch_pkg;

    // signed audio sample as delivered by the I2S frame
    typedef logic signed [23:0] sample_t;

    // lag between two samples, in sample periods
    typedef logic [7:0] lag_t;

    // window sum of absolute differences
    typedef logic [31:0] score_t;

    typedef enum logic [2:0] {
        S_IDLE  = 3'd0,
        S_WAIT  = 3'd1,
        S_WRITE = 3'd2,
        S_SWEEP = 3'd3,
        S_DRAIN = 3'd4
    } ctrl_state_e;

endpackage

/* src/i2s_recorder.sv */
`timescale 1ns/100ps

module i2s_recorder import pitch_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    i_bclk,
    input  logic    i_lrck,
    input  logic    i_sdata,
    input  logic    i_enable,
    output logic    o_sample_valid,
    output sample_t o_sample
);

    // extra bclk stage for edge detection
    logic [2:0]  bclk_sync;
    logic [1:0]  lrck_sync;
    logic [1:0]  sdata_sync;
    logic        bclk_rise;
    logic        lrck_prev;
    logic        left_word;
    logic [4:0]  bit_cnt;
    logic [22:0] shift_r;
    logic        word_done;

    assign bclk_rise = bclk_sync[1] & ~bclk_sync[2];

    // last data bit of a left word on this bclk edge
    assign word_done = bclk_rise && (lrck_sync[1] == lrck_prev) && left_word &&
                       (bit_cnt == 5'd23);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            bclk_sync      <= '0;
            lrck_sync      <= '0;
            sdata_sync     <= '0;
            lrck_prev      <= 1'b0;
            left_word      <= 1'b0;
            // wait for a word boundary before counting bits
            bit_cnt        <= 5'd24;
            o_sample_valid <= 1'b0;
        end else begin
            bclk_sync      <= {bclk_sync[1:0], i_bclk};
            lrck_sync      <= {lrck_sync[0], i_lrck};
            sdata_sync     <= {sdata_sync[0], i_sdata};
            o_sample_valid <= word_done & i_enable;
            if (bclk_rise) begin
                lrck_prev <= lrck_sync[1];
                if (lrck_sync[1] != lrck_prev) begin
                    // one-bit I2S delay so the MSB comes on the next edge
                    left_word <= ~lrck_sync[1];
                    bit_cnt   <= '0;
                end else if (bit_cnt < 5'd24) begin
                    bit_cnt <= bit_cnt + 5'd1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (bclk_rise && bit_cnt < 5'd24) begin
            shift_r <= {shift_r[21:0], sdata_sync[1]};
        end
        if (word_done && i_enable) begin
            o_sample <= {shift_r, sdata_sync[1]};
        end
    end

endmodule

/* src/ring_buffer.sv */
`timescale 1ns/100ps

module ring_buffer import pitch_pkg::*; #(
    parameter int WINDOW_LEN = 8,
    parameter int DELTA_LAST = 12
) (
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    i_clear,
    input  logic    i_wr_en,
    input  logic    i_sweep_valid,
    input  logic    i_sweep_first,
    input  logic    i_sweep_last,
    input  sample_t i_wr_data,
    input  lag_t    i_sweep_lag,
    output logic    o_tap_valid,
    output logic    o_tap_last,
    output lag_t    o_tap_lag,
    output sample_t o_tap_new,
    output sample_t o_tap_lagged,
    output sample_t o_tap_old,
    output sample_t o_tap_old_lagged
);

    // oldest tap is WINDOW_LEN + DELTA_LAST samples back
    localparam int BUFFER_LENGTH = WINDOW_LEN + DELTA_LAST + 1;
    localparam int PTR_W = $clog2(BUFFER_LENGTH);

    sample_t          mem [BUFFER_LENGTH];
    logic [PTR_W-1:0] ptr_r;
    logic [PTR_W-1:0] addr_new;
    logic [PTR_W-1:0] addr_lagged;
    logic [PTR_W-1:0] addr_old;
    logic [PTR_W-1:0] addr_old_lagged;

    // ptr points at the next free slot, so age 0 sits just behind it
    function automatic logic [PTR_W-1:0] tap_addr(input logic [PTR_W-1:0] ptr,
                                                  input int age);
        int idx;
        idx = int'(ptr) + BUFFER_LENGTH - 1 - age;
        if (idx >= BUFFER_LENGTH) begin
            idx = idx - BUFFER_LENGTH;
        end
        return PTR_W'(idx);
    endfunction

    always_comb begin
        addr_new        = tap_addr(ptr_r, 0);
        addr_lagged     = tap_addr(ptr_r, int'(i_sweep_lag));
        addr_old        = tap_addr(ptr_r, WINDOW_LEN);
        addr_old_lagged = tap_addr(ptr_r, WINDOW_LEN + int'(i_sweep_lag));
    end

    always_ff @(posedge i_clk) begin
        if (i_clear) begin
            for (int i = 0; i < BUFFER_LENGTH; i++) begin
                mem[i] <= '0;
            end
        end else if (i_wr_en) begin
            mem[ptr_r] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_sweep_valid) begin
            o_tap_new        <= mem[addr_new];
            o_tap_lagged     <= mem[addr_lagged];
            o_tap_old        <= mem[addr_old];
            o_tap_old_lagged <= mem[addr_old_lagged];
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            ptr_r       <= '0;
            o_tap_valid <= 1'b0;
            o_tap_last  <= 1'b0;
            o_tap_lag   <= '0;
        end else begin
            if (i_clear) begin
                ptr_r <= '0;
            end else if (i_wr_en) begin
                ptr_r <= (ptr_r == PTR_W'(BUFFER_LENGTH - 1)) ? '0 : ptr_r + 1'b1;
            end
            o_tap_valid <= i_sweep_valid;
            o_tap_last  <= i_sweep_valid & i_sweep_last;
            // lag tag restarts on the first lag, then steps with the sweep
            if (i_sweep_valid) begin
                o_tap_lag <= i_sweep_first ? i_sweep_lag : o_tap_lag + lag_t'(1);
            end
        end
    end

endmodule

/* src/pitch_ctrl.sv */
`timescale 1ns/100ps

module pitch_ctrl import pitch_pkg::*; #(
    parameter int DELTA_START = 3,
    parameter int DELTA_LAST  = 12
) (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_start,
    input  logic i_sample_valid,
    output logic o_enable,
    output logic o_clear,
    output logic o_wr_en,
    output logic o_sweep_valid,
    output logic o_sweep_first,
    output logic o_sweep_last,
    output lag_t o_sweep_lag
);

    ctrl_state_e state_r;
    lag_t        lag_r;
    logic [1:0]  drain_cnt;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r   <= S_IDLE;
            lag_r     <= '0;
            drain_cnt <= '0;
        end else begin
            case (state_r)
                S_IDLE: begin
                    if (i_start) begin
                        state_r <= S_WAIT;
                    end
                end
                // samples seen in any other state are dropped
                S_WAIT: begin
                    if (i_sample_valid) begin
                        state_r <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    state_r <= S_SWEEP;
                    lag_r   <= lag_t'(DELTA_START);
                end
                S_SWEEP: begin
                    if (lag_r == lag_t'(DELTA_LAST)) begin
                        state_r   <= S_DRAIN;
                        drain_cnt <= '0;
                    end else begin
                        lag_r <= lag_r + lag_t'(1);
                    end
                end
                // tap, score and pick stages empty out
                S_DRAIN: begin
                    if (drain_cnt == 2'd2) begin
                        state_r <= S_WAIT;
                    end else begin
                        drain_cnt <= drain_cnt + 2'd1;
                    end
                end
                default: begin
                    state_r <= S_IDLE;
                end
            endcase
        end
    end

    assign o_enable      = (state_r != S_IDLE);
    assign o_clear       = (state_r == S_IDLE);
    assign o_wr_en       = (state_r == S_WRITE);
    assign o_sweep_valid = (state_r == S_SWEEP);
    assign o_sweep_first = o_sweep_valid && (lag_r == lag_t'(DELTA_START));
    assign o_sweep_last  = o_sweep_valid && (lag_r == lag_t'(DELTA_LAST));
    assign o_sweep_lag   = lag_r;

endmodule

/* src/lag_scorer.sv */
`timescale 1ns/100ps

module lag_scorer import pitch_pkg::*; #(
    parameter int WINDOW_LEN  = 8,
    parameter int DELTA_START = 3,
    parameter int DELTA_LAST  = 12
) (
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    i_clear,
    input  logic    i_tap_valid,
    input  logic    i_tap_last,
    input  lag_t    i_tap_lag,
    input  sample_t i_tap_new,
    input  sample_t i_tap_lagged,
    input  sample_t i_tap_old,
    input  sample_t i_tap_old_lagged,
    output logic    o_score_valid,
    output logic    o_score_last,
    output lag_t    o_score_lag,
    output score_t  o_score
);

    localparam int NUM_LAGS = DELTA_LAST - DELTA_START + 1;
    // WINDOW_LEN magnitudes of up to 25 bits each
    localparam int SUM_W = 25 + $clog2(WINDOW_LEN);

    logic [SUM_W-1:0] score_r [NUM_LAGS];
    logic [24:0]      ad_new;
    logic [24:0]      ad_old;
    logic [SUM_W-1:0] score_next;
    int               slot;

    function automatic logic [24:0] abs_diff(input sample_t a, input sample_t b);
        logic signed [24:0] d;
        d = {a[23], a} - {b[23], b};
        if (d < 0) begin
            d = -d;
        end
        return d;
    endfunction

    always_comb begin
        slot = int'(i_tap_lag) - DELTA_START;
        if (slot < 0 || slot >= NUM_LAGS) begin
            slot = 0;
        end
        ad_new = abs_diff(i_tap_new, i_tap_lagged);
        ad_old = abs_diff(i_tap_old, i_tap_old_lagged);
        // newest pair enters the window, the pair WINDOW_LEN back leaves it
        score_next = score_r[slot] + SUM_W'(ad_new) - SUM_W'(ad_old);
    end

    always_ff @(posedge i_clk) begin
        if (i_clear) begin
            for (int i = 0; i < NUM_LAGS; i++) begin
                score_r[i] <= '0;
            end
        end else if (i_tap_valid) begin
            score_r[slot] <= score_next;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_tap_valid) begin
            o_score <= score_t'(score_next);
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_score_valid <= 1'b0;
            o_score_last  <= 1'b0;
            o_score_lag   <= '0;
        end else begin
            o_score_valid <= i_tap_valid;
            o_score_last  <= i_tap_valid & i_tap_last;
            if (i_tap_valid) begin
                o_score_lag <= i_tap_lag;
            end
        end
    end

endmodule

/* src/best_lag_picker.sv */
`timescale 1ns/100ps

module best_lag_picker import pitch_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_score_valid,
    input  logic   i_score_last,
    input  lag_t   i_score_lag,
    input  score_t i_score,
    output logic   o_pitch_valid,
    output lag_t   o_best_lag,
    output score_t o_best_score
);

    logic   restart_r;
    lag_t   run_lag;
    score_t run_score;
    lag_t   pub_lag;
    score_t pub_score;
    logic   take_new;
    lag_t   cand_lag;
    score_t cand_score;

    // lags arrive in ascending order, so a tie keeps the earlier one
    assign take_new   = restart_r || (i_score < run_score);
    assign cand_lag   = take_new ? i_score_lag : run_lag;
    assign cand_score = take_new ? i_score : run_score;

    // result leaves in the same cycle as the last score
    assign o_pitch_valid = i_score_valid & i_score_last;
    assign o_best_lag    = o_pitch_valid ? cand_lag : pub_lag;
    assign o_best_score  = o_pitch_valid ? cand_score : pub_score;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            restart_r <= 1'b1;
            run_lag   <= '0;
            run_score <= '0;
            pub_lag   <= '0;
            pub_score <= '0;
        end else if (i_score_valid) begin
            run_lag   <= cand_lag;
            run_score <= cand_score;
            restart_r <= i_score_last;
            // hold the result between sweeps
            if (i_score_last) begin
                pub_lag   <= cand_lag;
                pub_score <= cand_score;
            end
        end
    end

endmodule

/* src/pitch_top.sv */
`timescale 1ns/100ps

module pitch_top import pitch_pkg::*; #(
    parameter int WINDOW_LEN  = 8,
    parameter int DELTA_START = 3,
    parameter int DELTA_LAST  = 12
) (
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_start,
    input  logic   i_bclk,
    input  logic   i_lrck,
    input  logic   i_sdata,
    output logic   o_pitch_valid,
    output lag_t   o_best_lag,
    output score_t o_best_score
);

    logic    sample_valid;
    sample_t sample_data;
    logic    enable;
    logic    clear;
    logic    wr_en;
    logic    sweep_valid;
    logic    sweep_first;
    logic    sweep_last;
    lag_t    sweep_lag;
    logic    tap_valid;
    logic    tap_last;
    lag_t    tap_lag;
    sample_t tap_new;
    sample_t tap_lagged;
    sample_t tap_old;
    sample_t tap_old_lagged;
    logic    score_valid;
    logic    score_last;
    lag_t    score_lag;
    score_t  score_value;

    i2s_recorder u_rec (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_bclk         (i_bclk),
        .i_lrck         (i_lrck),
        .i_sdata        (i_sdata),
        .i_enable       (enable),
        .o_sample_valid (sample_valid),
        .o_sample       (sample_data)
    );

    pitch_ctrl #(
        .DELTA_START (DELTA_START),
        .DELTA_LAST  (DELTA_LAST)
    ) u_ctrl (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_start        (i_start),
        .i_sample_valid (sample_valid),
        .o_enable       (enable),
        .o_clear        (clear),
        .o_wr_en        (wr_en),
        .o_sweep_valid  (sweep_valid),
        .o_sweep_first  (sweep_first),
        .o_sweep_last   (sweep_last),
        .o_sweep_lag    (sweep_lag)
    );

    ring_buffer #(
        .WINDOW_LEN (WINDOW_LEN),
        .DELTA_LAST (DELTA_LAST)
    ) u_buf (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_clear          (clear),
        .i_wr_en          (wr_en),
        .i_sweep_valid    (sweep_valid),
        .i_sweep_first    (sweep_first),
        .i_sweep_last     (sweep_last),
        .i_wr_data        (sample_data),
        .i_sweep_lag      (sweep_lag),
        .o_tap_valid      (tap_valid),
        .o_tap_last       (tap_last),
        .o_tap_lag        (tap_lag),
        .o_tap_new        (tap_new),
        .o_tap_lagged     (tap_lagged),
        .o_tap_old        (tap_old),
        .o_tap_old_lagged (tap_old_lagged)
    );

    lag_scorer #(
        .WINDOW_LEN  (WINDOW_LEN),
        .DELTA_START (DELTA_START),
        .DELTA_LAST  (DELTA_LAST)
    ) u_scorer (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_clear          (clear),
        .i_tap_valid      (tap_valid),
        .i_tap_last       (tap_last),
        .i_tap_lag        (tap_lag),
        .i_tap_new        (tap_new),
        .i_tap_lagged     (tap_lagged),
        .i_tap_old        (tap_old),
        .i_tap_old_lagged (tap_old_lagged),
        .o_score_valid    (score_valid),
        .o_score_last     (score_last),
        .o_score_lag      (score_lag),
        .o_score          (score_value)
    );

    best_lag_picker u_picker (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_score_valid (score_valid),
        .i_score_last  (score_last),
        .i_score_lag   (score_lag),
        .i_score       (score_value),
        .o_pitch_valid (o_pitch_valid),
        .o_best_lag    (o_best_lag),
        .o_best_score  (o_best_score)
    );

endmodule

/* test/pitch_assertions.sv */
`timescale 1ns/100ps

module pitch_assertions import pitch_pkg::*; #(
    parameter int DELTA_START = 3,
    parameter int DELTA_LAST  = 12
) (
    input logic        i_clk,
    input logic        i_rst,
    input logic        i_pitch_valid,
    input lag_t        i_best_lag,
    input ctrl_state_e i_state
);

    // result strobe is a single cycle
    a_valid_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        i_pitch_valid |=> !i_pitch_valid)
        else $error("o_pitch_valid stayed high for more than one cycle");

    a_lag_range: assert property (@(posedge i_clk) disable iff (i_rst)
        i_pitch_valid |-> (i_best_lag >= lag_t'(DELTA_START) &&
                           i_best_lag <= lag_t'(DELTA_LAST)))
        else $error("o_best_lag outside the lag range");

    // nothing is captured before start
    a_no_idle_result: assert property (@(posedge i_clk) disable iff (i_rst)
        i_pitch_valid |-> (i_state != S_IDLE))
        else $error("result while the controller is idle");

endmodule

bind pitch_top pitch_assertions #(
    .DELTA_START (DELTA_START),
    .DELTA_LAST  (DELTA_LAST)
) u_assertions (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_pitch_valid (o_pitch_valid),
    .i_best_lag    (o_best_lag),
    .i_state       (u_ctrl.state_r)
);

/* test/tb_pitch.sv */
`timescale 1ns/100ps

module tb_pitch import pitch_pkg::*; ();

    localparam int WINDOW_LEN     = 8;
    localparam int DELTA_START    = 3;
    localparam int DELTA_LAST     = 12;
    localparam int CLK_PERIOD     = 40;
    localparam int BCLK_HALF      = 4;
    localparam int RESULT_TIMEOUT = 2000;

    logic   i_clk;
    logic   i_rst;
    logic   i_start;
    logic   i_bclk;
    logic   i_lrck;
    logic   i_sdata;
    logic   o_pitch_valid;
    lag_t   o_best_lag;
    score_t o_best_score;

    logic [31:0] lfsr_state;
    sample_t     history[$];
    lag_t        exp_lag_q[$];
    score_t      exp_score_q[$];
    lag_t        mon_lag;
    score_t      mon_score;
    lag_t        last_lag;
    score_t      last_score;
    int          results_seen;
    int          samples_sent;
    int          tie_count;
    int          error_count;

    pitch_top #(
        .WINDOW_LEN  (WINDOW_LEN),
        .DELTA_START (DELTA_START),
        .DELTA_LAST  (DELTA_LAST)
    ) i_dut (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_start       (i_start),
        .i_bclk        (i_bclk),
        .i_lrck        (i_lrck),
        .i_sdata       (i_sdata),
        .o_pitch_valid (o_pitch_valid),
        .o_best_lag    (o_best_lag),
        .o_best_score  (o_best_score)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // x^32 + x^22 + x^2 + x + 1 in right-shifting form
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = galois_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic next_sample(input int bits, output sample_t s);
        logic [31:0] v;
        draw_bits(bits, v);
        s = sample_t'(v[23:0]);
    endtask

    // zero before the first stored sample
    function automatic sample_t past_sample(input int age);
        int idx;
        sample_t s;
        idx = history.size() - 1 - age;
        s = '0;
        if (idx >= 0) begin
            s = history[idx];
        end
        return s;
    endfunction

    function automatic score_t window_score(input int lag);
        longint acc;
        longint d;
        acc = 0;
        for (int k = 0; k < WINDOW_LEN; k++) begin
            d = longint'(past_sample(k)) - longint'(past_sample(k + lag));
            if (d < 0) begin
                d = -d;
            end
            acc += d;
        end
        return score_t'(acc);
    endfunction

    function automatic int smallest_multiple(input int p);
        int m;
        m = p;
        while (m < DELTA_START) begin
            m += p;
        end
        return m;
    endfunction

    task automatic record_sample(input sample_t s);
        score_t best;
        score_t sc;
        lag_t   best_lag;
        history.push_back(s);
        best     = window_score(DELTA_START);
        best_lag = lag_t'(DELTA_START);
        for (int lag = DELTA_START + 1; lag <= DELTA_LAST; lag++) begin
            sc = window_score(lag);
            if (sc < best) begin
                best     = sc;
                best_lag = lag_t'(lag);
            end else if (sc == best) begin
                tie_count++;
            end
        end
        exp_lag_q.push_back(best_lag);
        exp_score_q.push_back(best);
    endtask

    task automatic check_lag(input lag_t actual, input lag_t expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t: %s lag is %0d, expected %0d", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "lag mismatch");
        end
    endtask

    task automatic check_score(input score_t actual, input score_t expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t: %s score is %0d, expected %0d", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "score mismatch");
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "flag mismatch");
        end
    endtask

    // every result is compared with the oldest pending model entry
    always @(negedge i_clk) begin
        if (!i_rst && o_pitch_valid) begin
            if (exp_lag_q.size() == 0) begin
                $display("a pitch result came at %0t with no sample pending", $time);
                $display("Errors found");
                $fatal(1, "unexpected result pulse");
            end else begin
                mon_lag   = exp_lag_q.pop_front();
                mon_score = exp_score_q.pop_front();
                check_lag(o_best_lag, mon_lag, "result");
                check_score(o_best_score, mon_score, "result");
                last_lag   = o_best_lag;
                last_score = o_best_score;
                results_seen++;
            end
        end
    end

    // data changes while bclk is low and the dut samples on the rise
    task automatic send_bit(input logic lr, input logic d);
        @(negedge i_clk);
        i_bclk  = 1'b0;
        i_lrck  = lr;
        i_sdata = d;
        repeat (BCLK_HALF) @(negedge i_clk);
        i_bclk = 1'b1;
        repeat (BCLK_HALF - 1) @(negedge i_clk);
    endtask

    // 32-bit slot with the MSB one bclk after the lrck edge
    task automatic send_slot(input logic lr, input sample_t w);
        logic d;
        for (int j = 0; j < 32; j++) begin
            d = 1'b0;
            if (j >= 1 && j <= 24) begin
                d = w[24 - j];
            end
            send_bit(lr, d);
        end
    endtask

    task automatic send_frame(input sample_t left, input sample_t right, input logic counted);
        if (counted) begin
            record_sample(left);
            samples_sent++;
        end
        send_slot(1'b0, left);
        send_slot(1'b1, right);
    endtask

    task automatic wait_for_results(input int want);
        int cycles;
        cycles = 0;
        while (results_seen < want) begin
            @(negedge i_clk);
            cycles++;
            if (cycles > RESULT_TIMEOUT) begin
                $display("timeout: no pitch result within %0d clock cycles", RESULT_TIMEOUT);
                $display("Errors found");
                $fatal(1, "result wait timed out");
            end
        end
        if (results_seen != want) begin
            $display("got %0d pitch results for %0d samples", results_seen, want);
            $display("Errors found");
            $fatal(1, "result count wrong");
        end
    endtask

    task automatic apply_reset();
        @(negedge i_clk);
        i_rst   = 1'b1;
        i_start = 1'b0;
        repeat (8) @(negedge i_clk);
        i_rst = 1'b0;
        history.delete();
        exp_lag_q.delete();
        exp_score_q.delete();
        results_seen = 0;
        samples_sent = 0;
    endtask

    // right slot first so the recorder sees an lrck edge before the left word
    task automatic prime_and_start();
        send_slot(1'b1, '0);
        @(negedge i_clk);
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
    endtask

    task automatic run_random(input int count, input int bits);
        sample_t l;
        sample_t r;
        repeat (count) begin
            next_sample(bits, l);
            next_sample(24, r);
            send_frame(l, r, 1'b1);
            wait_for_results(samples_sent);
        end
    endtask

    task automatic run_periodic(input int period, input int count);
        sample_t     pattern [16];
        sample_t     r;
        logic [31:0] v;
        // low nibble keeps the values of one period distinct
        for (int i = 0; i < period; i++) begin
            draw_bits(20, v);
            pattern[i] = {v[19:0], 4'(i)};
        end
        for (int n = 0; n < count; n++) begin
            next_sample(24, r);
            send_frame(pattern[n % period], r, 1'b1);
            wait_for_results(samples_sent);
            if (samples_sent >= WINDOW_LEN + period) begin
                check_lag(last_lag, lag_t'(smallest_multiple(period)), "periodic");
                check_score(last_score, '0, "periodic");
            end
        end
    endtask

    initial begin
        sample_t l;
        sample_t r;
        i_rst        = 1'b1;
        i_start      = 1'b0;
        i_bclk       = 1'b0;
        i_lrck       = 1'b1;
        i_sdata      = 1'b0;
        lfsr_state   = 32'd40;
        results_seen = 0;
        samples_sent = 0;
        tie_count    = 0;
        error_count  = 0;
        last_lag     = '0;
        last_score   = '0;

        apply_reset();
        @(negedge i_clk);
        check_flag(o_pitch_valid, 1'b0, "o_pitch_valid after reset");
        check_lag(o_best_lag, '0, "reset");
        check_score(o_best_score, '0, "reset");

        // frames before start are not stored
        send_slot(1'b1, '0);
        repeat (2) begin
            next_sample(24, l);
            next_sample(24, r);
            send_frame(l, r, 1'b0);
        end
        wait_for_results(0);
        @(negedge i_clk);
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        run_random(40, 24);

        apply_reset();
        prime_and_start();
        run_periodic(5, 30);

        // period at the low end of the lag range, its multiples tie at zero
        apply_reset();
        prime_and_start();
        run_periodic(3, 24);

        // two-bit samples make equal scores common
        apply_reset();
        prime_and_start();
        tie_count = 0;
        run_random(40, 2);
        if (tie_count == 0) begin
            $display("small-value run produced no tied scores");
            error_count++;
        end

        if (error_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "test failed");
        end
    end

endmodule

/* vlog.f */
src/pitch_pkg.sv
src/i2s_recorder.sv
src/ring_buffer.sv
src/pitch_ctrl.sv
src/lag_scorer.sv
src/best_lag_picker.sv
src/pitch_top.sv
test/pitch_assertions.sv
test/tb_pitch.sv

/* run_sim.sh */
#!/bin/sh
# compile tb_pitch with Verilator and run it, exit status gives pass or fail
verilator --binary --timing --assert -Wno-fatal --top-module tb_pitch -f vlog.f \
    -Mdir obj_dir -o tb_pitch_sim \
    && ./obj_dir/tb_pitch_sim \
    || { echo "simulation failed"; exit 1; }
